// File: source/valu_pkg.sv
/* Vector ALU package */

package valu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Datapath word and its byte enables
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned StrbBits  = ElenBits / 8;
  // Element count of one instruction
  localparam int unsigned VlBits    = 16;
  // Register-file word address
  localparam int unsigned VaddrBits = 10;
  // Instruction ids in flight across the machine
  localparam int unsigned NrVInsn   = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [StrbBits-1:0]        strb_t;
  typedef logic [VaddrBits-1:0]       vaddr_t;
  typedef logic [VlBits-1:0]          vlen_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VSLL = 3'd5
  } alu_op_e;

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  ////////////////////
  // Payloads
  ////////////////////

  // One instruction as sent by the lane sequencer
  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vew_e    vsew;
    vlen_t   vl;
    // Base word address of the destination
    vaddr_t  vd_addr;
    // High means unmasked
    logic    vm;
    logic    use_vs1;
    logic    use_vs2;
    // Scalar replaces vs1
    logic    use_scalar_op;
    elen_t   scalar_op;
  } vfu_operation_t;

  // One result word on its way to the register file
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Same 64 bits seen as packed elements of each width
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [0:0][63:0] d;
  } simd_word_u;

  // Elements packed in one word at a given width
  function automatic logic [3:0] elems_per_word(vew_e vsew);
    return 4'd8 >> vsew;
  endfunction

endpackage

// File: source/valu_simd_alu.sv
/* SIMD integer ALU */

`timescale 1ns/1ps

module valu_simd_alu (
  // Operand a is vs2, operand b is vs1 or the scalar
  input  valu_pkg::elen_t   operand_a_i,
  input  valu_pkg::elen_t   operand_b_i,
  input  valu_pkg::alu_op_e op_i,
  input  valu_pkg::vew_e    vew_i,
  output valu_pkg::elen_t   result_o
);

  import valu_pkg::*;

  simd_word_u opa;
  simd_word_u opb;
  simd_word_u res;

  assign opa      = operand_a_i;
  assign opb      = operand_b_i;
  assign result_o = res;

  always_comb begin
    res = '0;
    unique case (op_i)
      // Bitwise ops ignore element borders
      VAND: res.d[0] = opa.d[0] & opb.d[0];
      VOR:  res.d[0] = opa.d[0] | opb.d[0];
      VXOR: res.d[0] = opa.d[0] ^ opb.d[0];
      VADD, VSUB, VSLL: begin
        unique case (vew_i)
          EW8: begin
            for (int i = 0; i < 8; i++) begin
              case (op_i)
                VADD:    res.b[i] = opa.b[i] + opb.b[i];
                VSUB:    res.b[i] = opa.b[i] - opb.b[i];
                default: res.b[i] = opa.b[i] << opb.b[i][2:0];
              endcase
            end
          end
          EW16: begin
            for (int i = 0; i < 4; i++) begin
              case (op_i)
                VADD:    res.h[i] = opa.h[i] + opb.h[i];
                VSUB:    res.h[i] = opa.h[i] - opb.h[i];
                default: res.h[i] = opa.h[i] << opb.h[i][3:0];
              endcase
            end
          end
          EW32: begin
            for (int i = 0; i < 2; i++) begin
              case (op_i)
                VADD:    res.w[i] = opa.w[i] + opb.w[i];
                VSUB:    res.w[i] = opa.w[i] - opb.w[i];
                default: res.w[i] = opa.w[i] << opb.w[i][4:0];
              endcase
            end
          end
          default: begin
            // Single 64-bit element
            case (op_i)
              VADD:    res.d[0] = opa.d[0] + opb.d[0];
              VSUB:    res.d[0] = opa.d[0] - opb.d[0];
              default: res.d[0] = opa.d[0] << opb.d[0][5:0];
            endcase
          end
        endcase
      end
      // Unused opcodes give zero
      default: res = '0;
    endcase
  end

endmodule

// File: source/valu_insn_queue.sv
/* Instruction queue */

`timescale 1ns/1ps

module valu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Lane sequencer side
  input  valu_pkg::vfu_operation_t       operation_i,
  input  logic                           operation_valid_i,
  output logic                           operation_ready_o,
  // Issue stage side
  output valu_pkg::vfu_operation_t       issue_insn_o,
  output logic                           issue_valid_o,
  input  logic                           issue_done_i,
  // One pulse per granted result word
  input  logic                           commit_i,
  output logic [valu_pkg::NrVInsn-1:0]   done_o
);

  import valu_pkg::*;

  localparam int unsigned PntBits = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntBits = $clog2(InsnQueueDepth + 1);

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [CntBits-1:0] cnt_t;

  // Storage, written at the accept pointer only
  vfu_operation_t insn_q [InsnQueueDepth];

  pnt_t  accept_pnt_q, accept_pnt_d;
  pnt_t  issue_pnt_q, issue_pnt_d;
  pnt_t  commit_pnt_q, commit_pnt_d;
  // Instructions waiting to be issued or committed
  cnt_t  issue_cnt_q, issue_cnt_d;
  cnt_t  commit_cnt_q, commit_cnt_d;
  // Elements of the commit head still to be written
  vlen_t elem_left_q, elem_left_d;
  logic  ready_q;

  vfu_operation_t commit_insn;
  logic           commit_valid;
  logic           commit_last;
  logic           commit_empty;
  logic           accept;
  logic [3:0]     commit_elems;

  function automatic pnt_t bump(pnt_t pnt);
    return (pnt == pnt_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign operation_ready_o = ready_q;
  assign accept            = operation_valid_i && ready_q;

  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  assign commit_insn  = insn_q[commit_pnt_q];
  assign commit_valid = (commit_cnt_q != '0);
  assign commit_elems = elems_per_word(commit_insn.vsew);
  // Last word of the head, floored at zero for tails
  assign commit_last  = commit_i && commit_valid &&
                        (elem_left_q <= vlen_t'(commit_elems));
  // Nothing left to commit once this cycle's pop is done
  assign commit_empty = (commit_cnt_q == cnt_t'(commit_last));

  // Done goes out in the cycle of the last grant
  always_comb begin
    done_o = '0;
    if (commit_last) begin
      done_o[commit_insn.id] = 1'b1;
    end
  end

  ////////////////////
  // Pointers and counts
  ////////////////////

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    elem_left_d  = elem_left_q;
    issue_cnt_d  = issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
    commit_cnt_d = commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_last);

    if (accept) begin
      accept_pnt_d = bump(accept_pnt_q);
    end
    if (issue_done_i) begin
      issue_pnt_d = bump(issue_pnt_q);
    end

    if (commit_last) begin
      commit_pnt_d = bump(commit_pnt_q);
      // Next head starts with its full length
      elem_left_d  = insn_q[commit_pnt_d].vl;
    end else if (commit_i && commit_valid) begin
      elem_left_d = elem_left_q - vlen_t'(commit_elems);
    end

    // Incoming instruction becomes the commit head right away
    if (accept && commit_empty) begin
      elem_left_d = operation_i.vl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= operation_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      elem_left_q  <= '0;
      ready_q      <= 1'b0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      elem_left_q  <= elem_left_d;
      // Full means every slot still awaits its commit
      ready_q      <= (commit_cnt_d != cnt_t'(InsnQueueDepth));
    end
  end

  // Issue stage only finishes what this queue presented
  a_issue_done_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_done_i |-> issue_valid_o
  );

endmodule

// File: source/valu_issue_stage.sv
/* Issue stage */

`timescale 1ns/1ps

module valu_issue_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Head of the instruction queue
  input  valu_pkg::vfu_operation_t insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_done_o,
  // Operand queues, index 1 is vs2
  input  valu_pkg::elen_t [1:0]    operand_i,
  input  logic [1:0]               operand_valid_i,
  output logic [1:0]               operand_ready_o,
  // Predicate bytes
  input  valu_pkg::strb_t          mask_i,
  input  logic                     mask_valid_i,
  output logic                     mask_ready_o,
  // Toward the result queue
  output valu_pkg::result_t        result_o,
  output logic                     result_valid_o,
  input  logic                     result_ready_i
);

  import valu_pkg::*;

  // Instruction loaded and words left to fire
  logic   active_q;
  vlen_t  elem_left_q;
  vaddr_t word_idx_q;

  elen_t      scalar_rep;
  elen_t      alu_a;
  elen_t      alu_b;
  elen_t      alu_res;
  logic [3:0] word_elems;
  logic [3:0] elem_cnt;
  logic [3:0] nbytes;
  strb_t      tail_be;
  logic       inputs_ok;
  logic       fire;
  logic       last_word;

  ////////////////////
  // Scalar operand
  ////////////////////

  // Scalar repeated once per element
  always_comb begin
    unique case (insn_i.vsew)
      EW8:     scalar_rep = {8{insn_i.scalar_op[7:0]}};
      EW16:    scalar_rep = {4{insn_i.scalar_op[15:0]}};
      EW32:    scalar_rep = {2{insn_i.scalar_op[31:0]}};
      default: scalar_rep = insn_i.scalar_op;
    endcase
  end

  assign alu_a = operand_i[1];
  assign alu_b = insn_i.use_scalar_op ? scalar_rep : operand_i[0];

  valu_simd_alu u_simd_alu (
    .operand_a_i (alu_a),
    .operand_b_i (alu_b),
    .op_i        (insn_i.op),
    .vew_i       (insn_i.vsew),
    .result_o    (alu_res)
  );

  ////////////////////
  // Word control
  ////////////////////

  // Tail word carries fewer elements
  assign word_elems = elems_per_word(insn_i.vsew);
  assign last_word  = (elem_left_q <= vlen_t'(word_elems));
  assign elem_cnt   = last_word ? elem_left_q[3:0] : word_elems;
  assign nbytes     = elem_cnt << insn_i.vsew;
  assign tail_be    = strb_t'((9'd1 << nbytes) - 9'd1);

  // Mask only matters for predicated instructions
  assign inputs_ok = (operand_valid_i[1] || !insn_i.use_vs2) &&
                     (operand_valid_i[0] || !insn_i.use_vs1) &&
                     (mask_valid_i || insn_i.vm);
  assign fire      = active_q && inputs_ok && result_ready_i;

  assign operand_ready_o = fire ? {insn_i.use_vs2, insn_i.use_vs1} : 2'b00;
  assign mask_ready_o    = fire && !insn_i.vm;
  assign insn_done_o     = fire && last_word;

  assign result_valid_o = fire;
  assign result_o.id    = insn_i.id;
  assign result_o.addr  = insn_i.vd_addr + word_idx_q;
  assign result_o.wdata = alu_res;
  assign result_o.be    = tail_be & (insn_i.vm ? {StrbBits{1'b1}} : mask_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      elem_left_q <= '0;
      word_idx_q  <= '0;
    end else if (!active_q) begin
      // Take the element count one cycle after the head shows up
      if (insn_valid_i) begin
        active_q    <= 1'b1;
        elem_left_q <= insn_i.vl;
        word_idx_q  <= '0;
      end
    end else if (fire) begin
      elem_left_q <= elem_left_q - vlen_t'(elem_cnt);
      word_idx_q  <= word_idx_q + 1'b1;
      if (last_word) begin
        active_q <= 1'b0;
      end
    end
  end

  // Queue keeps the head presented until its last word fires
  a_head_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) active_q |-> insn_valid_i
  );

endmodule

// File: source/valu_result_queue.sv
/* Result queue */

`timescale 1ns/1ps

module valu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // From the issue stage
  input  valu_pkg::result_t result_i,
  input  logic              result_valid_i,
  output logic              result_ready_o,
  // Register file write port
  output logic              result_req_o,
  output valu_pkg::vid_t    result_id_o,
  output valu_pkg::vaddr_t  result_addr_o,
  output valu_pkg::elen_t   result_wdata_o,
  output valu_pkg::strb_t   result_be_o,
  input  logic              result_gnt_i,
  // One pulse per written word
  output logic              commit_o
);

  import valu_pkg::*;

  localparam int unsigned PntBits = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntBits = $clog2(ResultQueueDepth + 1);

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [CntBits-1:0] cnt_t;

  result_t fifo_q [ResultQueueDepth];
  pnt_t    wr_pnt_q;
  pnt_t    rd_pnt_q;
  cnt_t    cnt_q;
  result_t head;
  logic    push;
  logic    pop;

  function automatic pnt_t bump(pnt_t pnt);
    return (pnt == pnt_t'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Back-pressure when every slot holds a word
  assign result_ready_o = (cnt_q != cnt_t'(ResultQueueDepth));
  assign push           = result_valid_i && result_ready_o;

  // Head stays put until granted
  assign head         = fifo_q[rd_pnt_q];
  assign result_req_o = (cnt_q != '0);
  assign pop          = result_req_o && result_gnt_i;
  assign commit_o     = pop;

  assign result_id_o    = head.id;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_pnt_q] <= result_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= bump(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= bump(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  // Register file grants only a pending request
  a_gnt_has_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) result_gnt_i |-> result_req_o
  );

endmodule

// File: source/valu_top.sv
/* Vector ALU top level */

`timescale 1ns/1ps

module valu_top #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Lane sequencer
  input  valu_pkg::vfu_operation_t     operation_i,
  input  logic                         operation_valid_i,
  output logic                         operation_ready_o,
  // Operand queues
  input  valu_pkg::elen_t [1:0]        operand_i,
  input  logic [1:0]                   operand_valid_i,
  output logic [1:0]                   operand_ready_o,
  // Mask
  input  valu_pkg::strb_t              mask_i,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  // Register file
  output logic                         result_req_o,
  output valu_pkg::vid_t               result_id_o,
  output valu_pkg::vaddr_t             result_addr_o,
  output valu_pkg::elen_t              result_wdata_o,
  output valu_pkg::strb_t              result_be_o,
  input  logic                         result_gnt_i,
  // Per-id completion
  output logic [valu_pkg::NrVInsn-1:0] done_o
);

  import valu_pkg::*;

  // Queue head toward the issue stage
  vfu_operation_t issue_insn;
  logic           issue_valid;
  logic           issue_done;
  // Issue stage toward the result queue
  result_t        result;
  logic           result_valid;
  logic           result_ready;
  // Grant feedback for element counting
  logic           commit;

  valu_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) u_insn_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .operation_i       (operation_i),
    .operation_valid_i (operation_valid_i),
    .operation_ready_o (operation_ready_o),
    .issue_insn_o      (issue_insn),
    .issue_valid_o     (issue_valid),
    .issue_done_i      (issue_done),
    .commit_i          (commit),
    .done_o            (done_o)
  );

  valu_issue_stage u_issue_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .insn_done_o     (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_o        (result),
    .result_valid_o  (result_valid),
    .result_ready_i  (result_ready)
  );

  valu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth)
  ) u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result_i       (result),
    .result_valid_i (result_valid),
    .result_ready_o (result_ready),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .commit_o       (commit)
  );

endmodule

// File: verification/valu_tb.sv
/* Vector ALU testbench */

`timescale 1ns/1ps

module valu_tb;

  import valu_pkg::*;

  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam logic [31:0] Seed             = 32'h9fdc_bc76;

  // Expected register-file word and whether it ends its instruction
  typedef struct packed {
    result_t res;
    logic    last;
  } exp_word_t;

  logic                 clk_i;
  logic                 rst_ni;
  vfu_operation_t       operation_i;
  logic                 operation_valid_i;
  logic                 operation_ready_o;
  elen_t [1:0]          operand_i;
  logic [1:0]           operand_valid_i;
  logic [1:0]           operand_ready_o;
  strb_t                mask_i;
  logic                 mask_valid_i;
  logic                 mask_ready_o;
  logic                 result_req_o;
  vid_t                 result_id_o;
  vaddr_t               result_addr_o;
  elen_t                result_wdata_o;
  strb_t                result_be_o;
  logic                 result_gnt_i;
  logic [NrVInsn-1:0]   done_o;

  // Operand streams in issue order, vs2 and vs1 and mask
  elen_t       vs2_q[$];
  elen_t       vs1_q[$];
  strb_t       mask_q[$];
  exp_word_t   exp_q[$];
  logic [31:0] rng_q;
  logic [31:0] gnt_rng_q;
  vid_t        next_id;
  int unsigned words_issued;
  logic        hold_gnt;
  logic        random_gnt;
  string       current_test;

  valu_top #(
    .InsnQueueDepth   (InsnQueueDepth),
    .ResultQueueDepth (ResultQueueDepth)
  ) u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .operation_i       (operation_i),
    .operation_valid_i (operation_valid_i),
    .operation_ready_o (operation_ready_o),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .mask_i            (mask_i),
    .mask_valid_i      (mask_valid_i),
    .mask_ready_o      (mask_ready_o),
    .result_req_o      (result_req_o),
    .result_id_o       (result_id_o),
    .result_addr_o     (result_addr_o),
    .result_wdata_o    (result_wdata_o),
    .result_be_o       (result_be_o),
    .result_gnt_i      (result_gnt_i),
    .done_o            (done_o)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  // All ones across one element of the given width
  function automatic elen_t elem_ones(input vew_e ew);
    int unsigned w;
    w = 8 << ew;
    return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  endfunction

  // Low element of s copied into every element slot
  function automatic elen_t splat(input elen_t s, input vew_e ew);
    int unsigned w;
    elen_t       res;
    w   = 8 << ew;
    res = '0;
    for (int unsigned e = 0; e < 64 / w; e++) begin
      res |= (s & elem_ones(ew)) << (e * w);
    end
    return res;
  endfunction

  // Reference result, one element at a time with no carry between them
  function automatic elen_t ref_alu(input alu_op_e op, input vew_e ew,
                                    input elen_t a, input elen_t b);
    int unsigned w;
    elen_t       res;
    elen_t       ea;
    elen_t       eb;
    elen_t       er;
    w   = 8 << ew;
    res = '0;
    for (int unsigned e = 0; e < 64 / w; e++) begin
      ea = (a >> (e * w)) & elem_ones(ew);
      eb = (b >> (e * w)) & elem_ones(ew);
      case (op)
        VADD:    er = ea + eb;
        VSUB:    er = ea - eb;
        VAND:    er = ea & eb;
        VOR:     er = ea | eb;
        VXOR:    er = ea ^ eb;
        default: er = ea << (eb % w);
      endcase
      res |= (er & elem_ones(ew)) << (e * w);
    end
    return res;
  endfunction

  // Byte enables for n valid elements from the bottom of the word
  function automatic strb_t tail_bytes(input int unsigned n, input vew_e ew);
    strb_t be;
    be = '0;
    for (int unsigned i = 0; i < StrbBits; i++) begin
      be[i] = (i < n * (1 << ew));
    end
    return be;
  endfunction

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped after an error");
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic compare_word(input elen_t exp, input elen_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: wdata expected %h actual %h", current_test, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_be(input strb_t exp, input strb_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: be expected %b actual %b", current_test, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_addr(input vaddr_t exp, input vaddr_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: addr expected %h actual %h", current_test, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_id(input vid_t exp, input vid_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: id expected %0d actual %0d", current_test, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_done(input logic [NrVInsn-1:0] exp, input logic [NrVInsn-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: done expected %b actual %b", current_test, exp, act);
      abort_run();
    end
  endtask

  ////////////////////
  // Background processes
  ////////////////////

  // Streams advance on the edge after a sampled ready
  always begin : operand_feeder
    logic [1:0] take_vs;
    logic       take_mask;
    @(negedge clk_i);
    take_vs   = operand_ready_o;
    take_mask = mask_ready_o;
    @(posedge clk_i);
    #10;
    if ((take_vs[1] && vs2_q.size() == 0) || (take_vs[0] && vs1_q.size() == 0) ||
        (take_mask && mask_q.size() == 0)) begin
      $display("Operand or mask consumed while none was offered");
      abort_run();
    end
    if (take_vs[1]) void'(vs2_q.pop_front());
    if (take_vs[0]) void'(vs1_q.pop_front());
    if (take_mask) void'(mask_q.pop_front());
    operand_valid_i[1] = (vs2_q.size() != 0);
    operand_valid_i[0] = (vs1_q.size() != 0);
    mask_valid_i       = (mask_q.size() != 0);
    operand_i[1]       = operand_valid_i[1] ? vs2_q[0] : '0;
    operand_i[0]       = operand_valid_i[0] ? vs1_q[0] : '0;
    mask_i             = mask_valid_i ? mask_q[0] : '0;
  end

  // Register file grant, stalled at random when asked
  always begin
    @(posedge clk_i);
    #10;
    gnt_rng_q    = xorshift(gnt_rng_q);
    result_gnt_i = result_req_o && !hold_gnt && (!random_gnt || gnt_rng_q[1:0] != 2'b00);
  end

  // Every granted word is checked, done only on the last one
  always @(negedge clk_i) begin : result_checker
    exp_word_t          exp;
    logic [NrVInsn-1:0] exp_done;
    if (rst_ni && result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("Register file write with no word expected");
        abort_run();
      end
      exp      = exp_q.pop_front();
      exp_done = '0;
      if (exp.last) exp_done[exp.res.id] = 1'b1;
      compare_id(exp.res.id, result_id_o);
      compare_addr(exp.res.addr, result_addr_o);
      compare_word(exp.res.wdata, result_wdata_o);
      compare_be(exp.res.be, result_be_o);
      compare_done(exp_done, done_o);
    end else if (rst_ni) begin
      compare_done('0, done_o);
    end
  end

  // Budget grows with every planned word
  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < 1000 + 200 * words_issued) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout in %s after %0d cycles", current_test, cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic send_insn(input vfu_operation_t insn);
    logic taken;
    operation_i       = insn;
    operation_valid_i = 1'b1;
    taken             = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = operation_ready_o;
      @(posedge clk_i);
      #10;
    end
    operation_valid_i = 1'b0;
  endtask

  // Plans operands and expected words, then hands the instruction over
  task automatic run_insn(input alu_op_e op, input vew_e ew, input vlen_t vl,
                          input logic vm, input logic use_scalar);
    vfu_operation_t insn;
    exp_word_t      exp;
    elen_t          a;
    elen_t          b;
    strb_t          m;
    int unsigned    epw;
    int unsigned    left;
    int unsigned    n;
    insn               = '0;
    insn.id            = next_id;
    insn.op            = op;
    insn.vsew          = ew;
    insn.vl            = vl;
    insn.vd_addr       = vaddr_t'(next_rand() % 1000);
    insn.vm            = vm;
    insn.use_vs1       = !use_scalar;
    insn.use_vs2       = 1'b1;
    insn.use_scalar_op = use_scalar;
    insn.scalar_op     = {next_rand(), next_rand()};
    next_id            = next_id + 1'b1;
    epw                = 8 >> ew;
    left               = 32'(vl);
    for (int w = 0; left > 0; w++) begin
      a = {next_rand(), next_rand()};
      b = {next_rand(), next_rand()};
      vs2_q.push_back(a);
      if (use_scalar) begin
        b = splat(insn.scalar_op, ew);
      end else begin
        vs1_q.push_back(b);
      end
      m = '1;
      if (!vm) begin
        m = strb_t'(next_rand());
        mask_q.push_back(m);
      end
      n              = (left < epw) ? left : epw;
      exp.res.id     = insn.id;
      exp.res.addr   = insn.vd_addr + vaddr_t'(w);
      exp.res.wdata  = ref_alu(op, ew, a, b);
      exp.res.be     = tail_bytes(n, ew) & m;
      exp.last       = (left <= epw);
      exp_q.push_back(exp);
      left -= n;
      words_issued++;
    end
    send_insn(insn);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic add_sub_widths();
    current_test = "add_sub_widths";
    for (int i = 0; i < 4; i++) begin
      run_insn(VADD, vew_e'(i), vlen_t'(2 * (8 >> i)), 1'b1, 1'b0);
      run_insn(VSUB, vew_e'(i), vlen_t'(3 * (8 >> i)), 1'b1, 1'b0);
    end
    wait_idle();
  endtask

  // Last two use the replicated scalar in place of vs1
  task automatic logic_and_shift();
    current_test = "logic_and_shift";
    run_insn(VAND, EW16, 16'd8, 1'b1, 1'b0);
    run_insn(VOR, EW32, 16'd4, 1'b1, 1'b0);
    run_insn(VXOR, EW64, 16'd2, 1'b1, 1'b0);
    run_insn(VSLL, EW8, 16'd16, 1'b1, 1'b0);
    run_insn(VSLL, EW32, 16'd6, 1'b1, 1'b1);
    run_insn(VAND, EW8, 16'd8, 1'b1, 1'b1);
    wait_idle();
  endtask

  task automatic tail_words();
    current_test = "tail_words";
    run_insn(VADD, EW16, 16'd7, 1'b1, 1'b0);
    run_insn(VOR, EW8, 16'd11, 1'b1, 1'b0);
    run_insn(VSUB, EW32, 16'd3, 1'b1, 1'b0);
    run_insn(VXOR, EW64, 16'd1, 1'b1, 1'b0);
    wait_idle();
  endtask

  task automatic masked_words();
    current_test = "masked_words";
    run_insn(VADD, EW8, 16'd13, 1'b0, 1'b0);
    run_insn(VSUB, EW32, 16'd5, 1'b0, 1'b0);
    run_insn(VSLL, EW16, 16'd6, 1'b0, 1'b1);
    wait_idle();
  endtask

  // Fill the instruction queue with grants held, then drain under stalls
  task automatic queue_backpressure();
    current_test = "queue_backpressure";
    hold_gnt     = 1'b1;
    for (int k = 0; k < InsnQueueDepth; k++) begin
      run_insn(alu_op_e'(k % 6), vew_e'(k % 4), vlen_t'(5 + 3 * k),
               (k % 2) == 0, (k % 4) == 3);
    end
    if (operation_ready_o) begin
      $display("Instruction ready stayed high with the queue full");
      abort_run();
    end
    repeat (5) @(posedge clk_i);
    #10;
    random_gnt = 1'b1;
    hold_gnt   = 1'b0;
    wait_idle();
    random_gnt = 1'b0;
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    operation_i       = '0;
    operation_valid_i = 1'b0;
    operand_i         = '0;
    operand_valid_i   = '0;
    mask_i            = '0;
    mask_valid_i      = 1'b0;
    result_gnt_i      = 1'b0;
    rng_q             = Seed;
    gnt_rng_q         = xorshift(Seed);
    next_id           = '0;
    words_issued      = 0;
    hold_gnt          = 1'b0;
    random_gnt        = 1'b0;
    current_test      = "reset";

    // Reset held over 8 rising edges
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    if (operation_ready_o || result_req_o || operand_ready_o != '0 ||
        mask_ready_o || done_o != '0) begin
      $display("An output was active during reset");
      abort_run();
    end
    @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #10;
    if (!operation_ready_o) begin
      $display("Instruction ready did not rise after reset");
      abort_run();
    end

    add_sub_widths();
    logic_and_shift();
    tail_words();
    masked_words();
    queue_backpressure();

    if (exp_q.size() == 0 && vs1_q.size() == 0 && vs2_q.size() == 0 && mask_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Words or operands left over at the end of the run");
      abort_run();
    end
  end

endmodule

// File: files.f
source/valu_pkg.sv
source/valu_simd_alu.sv
source/valu_insn_queue.sv
source/valu_issue_stage.sv
source/valu_result_queue.sv
source/valu_top.sv
verification/valu_tb.sv

// File: Makefile
# Verilator flow for the vector ALU testbench

VERILATOR ?= verilator
TOP       ?= valu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Exit status of the simulation is the result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
